// ==== camera_front_end.f ====
+incdir+source
+incdir+tb
source/camera_pkg.sv
source/csi2_packet_parser.sv
source/pan_crop.sv
source/exposure_metering.sv
source/frame_output_packer.sv
source/camera_front_end.sv
tb/camera_front_end_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the camera front end testbench with Verilator and runs it.
# The exit status is the simulator's, non-zero when the run fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f camera_front_end.f \
    --top-module camera_front_end_tb \
    -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

if [ ! -x obj_dir/Vcamera_front_end_tb ]; then
    echo "Simulation executable not found"
    exit 1
fi

./obj_dir/Vcamera_front_end_tb
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "Simulation run ended with status $run_status"
    exit $run_status
fi

exit 0

// ==== source/camera_defines.svh ====
/*
 * Camera front end parameters
 * Pixel and coordinate widths, output FIFO sizing and metering scale
 */

`ifndef CAMERA_DEFINES_SVH
`define CAMERA_DEFINES_SVH

// RAW8 pixel
`define PIXEL_WIDTH 8

// Column and row counters, enough for 2047 x 2047
`define COORD_WIDTH 11

// Output packer FIFO entries
`define OUTPUT_FIFO_DEPTH 32

// Credits held by the packer after reset
`define OUTPUT_CREDITS 8

// Frame sum is divided by 2^METERING_SHIFT before saturation
`define METERING_SHIFT 8

`endif

// ==== source/camera_front_end.sv ====
/*
 * Camera front end
 * CSI-2 parsing, pan crop and exposure metering merged into one
 * credit-controlled output stream
 */

`timescale 1ns/1ps
`default_nettype none

module camera_front_end (
    input  wire logic                     mipi_byte_clock,
    input  wire logic                     mipi_byte_reset_n,
    input  wire camera_pkg::mipi_byte_t   byte_i,
    input  wire camera_pkg::crop_window_t crop_window_i,
    input  wire logic                     credit_return_i,
    output camera_pkg::output_word_t      word_o,
    output logic                          overflow_o
);

    camera_pkg::pixel_t parsed_pixel;    // Full frame, feeds crop and meter
    camera_pkg::pixel_t cropped_pixel;
    logic [7:0]         metering;
    logic               metering_valid;

    csi2_packet_parser csi2_packet_parser_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .byte_i            (byte_i),
        .pixel_o           (parsed_pixel)
    );

    pan_crop pan_crop_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .window_i          (crop_window_i),
        .pixel_i           (parsed_pixel),
        .pixel_o           (cropped_pixel)
    );

    exposure_metering exposure_metering_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (parsed_pixel),
        .metering_o        (metering),
        .metering_valid_o  (metering_valid)
    );

    frame_output_packer frame_output_packer_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .pixel_i           (cropped_pixel),
        .metering_i        (metering),
        .metering_valid_i  (metering_valid),
        .credit_return_i   (credit_return_i),
        .word_o            (word_o),
        .overflow_o        (overflow_o)
    );

endmodule

`default_nettype wire

// ==== source/camera_pkg.sv ====
/*
 * Camera front end types
 * CSI-2 data types, parser states and the structs passed between blocks
 */

`default_nettype none

`include "camera_defines.svh"

package camera_pkg;

    typedef enum logic [5:0] {
        DT_FRAME_START = 6'h00,
        DT_FRAME_END   = 6'h01,
        DT_RAW8        = 6'h2A
    } csi2_data_type_e;

    typedef enum logic [1:0] {
        PS_HEADER,
        PS_PAYLOAD,
        PS_CRC
    } parser_state_e;

    typedef struct packed {
        logic                    valid;
        logic                    packet_start;  // First byte of a packet
        logic [7:0]              data;
    } mipi_byte_t;

    typedef struct packed {
        logic                    valid;
        logic                    frame_start;
        logic                    frame_end;
        logic [`COORD_WIDTH-1:0] x;
        logic [`COORD_WIDTH-1:0] y;
        logic [`PIXEL_WIDTH-1:0] data;
    } pixel_t;

    // Start bounds inclusive, end bounds exclusive
    typedef struct packed {
        logic [`COORD_WIDTH-1:0] x_start;
        logic [`COORD_WIDTH-1:0] x_end;
        logic [`COORD_WIDTH-1:0] y_start;
        logic [`COORD_WIDTH-1:0] y_end;
    } crop_window_t;

    typedef struct packed {
        logic                    valid;
        logic                    is_metering;   // Last word of a frame
        logic [`PIXEL_WIDTH-1:0] data;
    } output_word_t;

endpackage

`default_nettype wire

// ==== source/csi2_packet_parser.sv ====
/*
 * CSI-2 packet parser
 * Walks the single-lane byte stream and turns RAW8 line payloads
 * into pixels with coordinates and frame markers
 */

`timescale 1ns/1ps
`default_nettype none

`include "camera_defines.svh"

module csi2_packet_parser (
    input  wire logic                   mipi_byte_clock,
    input  wire logic                   mipi_byte_reset_n,
    input  wire camera_pkg::mipi_byte_t byte_i,
    output camera_pkg::pixel_t          pixel_o
);

    camera_pkg::parser_state_e   state_q;
    camera_pkg::csi2_data_type_e data_type_q;
    logic [1:0]                  header_count_q;   // Next header byte, 0 while idle
    logic [15:0]                 word_count_q;
    logic [15:0]                 remaining_q;      // Payload bytes still to come
    logic                        crc_second_q;
    logic [`COORD_WIDTH-1:0]     x_q;
    logic [`COORD_WIDTH-1:0]     y_q;
    logic                        in_frame_q;
    logic                        long_packet;
    logic                        is_raw8;

    // Data types 0x10 and up are long packets with payload and CRC
    assign long_packet = data_type_q[5:4] != 2'b00;
    assign is_raw8     = data_type_q == camera_pkg::DT_RAW8;

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state_q        <= camera_pkg::PS_HEADER;
            data_type_q    <= camera_pkg::DT_FRAME_START;
            header_count_q <= 2'd0;
            word_count_q   <= '0;
            remaining_q    <= '0;
            crc_second_q   <= 1'b0;
            x_q            <= '0;
            y_q            <= '0;
            in_frame_q     <= 1'b0;
            pixel_o        <= '0;
        end else begin
            pixel_o.valid       <= 1'b0;
            pixel_o.frame_start <= 1'b0;
            pixel_o.frame_end   <= 1'b0;

            if (byte_i.valid && byte_i.packet_start) begin
                // Data identifier byte, virtual channel bits dropped
                data_type_q    <= camera_pkg::csi2_data_type_e'(byte_i.data[5:0]);
                header_count_q <= 2'd1;
                state_q        <= camera_pkg::PS_HEADER;
            end else if (byte_i.valid) begin
                case (state_q)
                    camera_pkg::PS_HEADER: begin
                        if (header_count_q == 2'd1) begin
                            word_count_q[7:0] <= byte_i.data;
                            header_count_q    <= 2'd2;
                        end else if (header_count_q == 2'd2) begin
                            word_count_q[15:8] <= byte_i.data;
                            header_count_q     <= 2'd3;
                        end else if (header_count_q == 2'd3) begin
                            header_count_q <= 2'd0;        // ECC byte not checked
                            case (data_type_q)
                                camera_pkg::DT_FRAME_START: begin
                                    in_frame_q          <= 1'b1;
                                    y_q                 <= '0;
                                    pixel_o.frame_start <= 1'b1;
                                end
                                camera_pkg::DT_FRAME_END: begin
                                    in_frame_q        <= 1'b0;
                                    y_q               <= '0;
                                    pixel_o.frame_end <= 1'b1;
                                end
                                default: begin
                                    if (long_packet) begin
                                        remaining_q  <= word_count_q;
                                        x_q          <= '0;
                                        crc_second_q <= 1'b0;
                                        state_q      <= (word_count_q == 16'd0) ?
                                                        camera_pkg::PS_CRC :
                                                        camera_pkg::PS_PAYLOAD;
                                    end
                                end
                            endcase
                        end
                    end
                    camera_pkg::PS_PAYLOAD: begin
                        if (is_raw8) begin
                            pixel_o.valid <= 1'b1;
                            pixel_o.x     <= x_q;
                            pixel_o.y     <= y_q;
                            pixel_o.data  <= byte_i.data;
                            x_q           <= x_q + 1'b1;
                        end
                        remaining_q <= remaining_q - 1'b1;
                        if (remaining_q == 16'd1) begin
                            state_q <= camera_pkg::PS_CRC;
                        end
                    end
                    camera_pkg::PS_CRC: begin
                        crc_second_q <= 1'b1;                  // Two CRC bytes skipped
                        if (crc_second_q) begin
                            state_q <= camera_pkg::PS_HEADER;
                            if (is_raw8) begin
                                y_q <= y_q + 1'b1;
                            end
                        end
                    end
                    default: state_q <= camera_pkg::PS_HEADER;
                endcase
            end
        end
    end

    // Receiver must wrap every RAW8 line in frame start and frame end packets
    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        pixel_o.valid |-> in_frame_q)
        else $error("RAW8 pixel received outside a frame");

endmodule

`default_nettype wire

// ==== source/exposure_metering.sv ====
/*
 * Exposure meter
 * Sums every pixel of a frame and reports the scaled, saturated
 * average brightness at frame end
 */

`timescale 1ns/1ps
`default_nettype none

`include "camera_defines.svh"

module exposure_metering (
    input  wire logic               mipi_byte_clock,
    input  wire logic               mipi_byte_reset_n,
    input  wire camera_pkg::pixel_t pixel_i,
    output logic [7:0]              metering_o,
    output logic                    metering_valid_o
);

    // Wide enough for a full 2047 x 2047 frame of white pixels
    localparam int ACC_WIDTH = 2 * `COORD_WIDTH + `PIXEL_WIDTH;

    logic [ACC_WIDTH-1:0]    acc_q;
    logic [ACC_WIDTH-1:0]    sum_next;
    logic [ACC_WIDTH-1:0]    scaled;
    logic [`PIXEL_WIDTH-1:0] addend;

    assign addend = pixel_i.valid ? pixel_i.data : '0;

    always_comb begin
        if (pixel_i.frame_start) begin
            sum_next = ACC_WIDTH'(addend);         // Restart on a new frame
        end else begin
            sum_next = acc_q + ACC_WIDTH'(addend);
        end
        scaled = sum_next >> `METERING_SHIFT;
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            acc_q            <= '0;
            metering_valid_o <= 1'b0;
        end else begin
            acc_q            <= sum_next;
            metering_valid_o <= pixel_i.frame_end;
        end
    end

    always_ff @(posedge mipi_byte_clock) begin
        if (pixel_i.frame_end) begin
            if (|scaled[ACC_WIDTH-1:8]) begin
                metering_o <= 8'hff;               // Saturate bright frames
            end else begin
                metering_o <= scaled[7:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_output_packer.sv ====
/*
 * Frame output packer
 * Queues cropped pixels and the metering byte in one FIFO and sends
 * them downstream under credit-based flow control
 */

`timescale 1ns/1ps
`default_nettype none

`include "camera_defines.svh"

module frame_output_packer (
    input  wire logic                 mipi_byte_clock,
    input  wire logic                 mipi_byte_reset_n,
    input  wire camera_pkg::pixel_t   pixel_i,
    input  wire logic [7:0]           metering_i,
    input  wire logic                 metering_valid_i,
    input  wire logic                 credit_return_i,
    output camera_pkg::output_word_t  word_o,
    output logic                      overflow_o
);

    localparam int DEPTH        = `OUTPUT_FIFO_DEPTH;
    localparam int ADDR_WIDTH   = $clog2(DEPTH);
    localparam int CREDIT_WIDTH = $clog2(`OUTPUT_CREDITS + 1);

    // Entry is the metering tag above the data byte
    logic [`PIXEL_WIDTH:0]   fifo_mem [DEPTH];
    logic [ADDR_WIDTH:0]     wr_ptr_q;             // Extra bit tells full from empty
    logic [ADDR_WIDTH:0]     rd_ptr_q;
    logic [CREDIT_WIDTH-1:0] credits_q;
    logic                    write;
    logic                    full;
    logic                    empty;
    logic                    pop;
    logic [`PIXEL_WIDTH:0]   write_entry;
    logic [`PIXEL_WIDTH:0]   read_entry;

    assign write       = pixel_i.valid || metering_valid_i;
    assign write_entry = metering_valid_i ? {1'b1, metering_i} : {1'b0, pixel_i.data};

    assign empty = wr_ptr_q == rd_ptr_q;
    assign full  = (wr_ptr_q[ADDR_WIDTH] != rd_ptr_q[ADDR_WIDTH]) &&
                   (wr_ptr_q[ADDR_WIDTH-1:0] == rd_ptr_q[ADDR_WIDTH-1:0]);
    assign pop   = !empty && (credits_q != '0);

    assign read_entry = fifo_mem[rd_ptr_q[ADDR_WIDTH-1:0]];

    always_ff @(posedge mipi_byte_clock) begin
        if (write && !full) begin
            fifo_mem[wr_ptr_q[ADDR_WIDTH-1:0]] <= write_entry;
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            credits_q  <= CREDIT_WIDTH'(`OUTPUT_CREDITS);
            overflow_o <= 1'b0;
            word_o     <= '0;
        end else begin
            if (write && !full) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end else if (write) begin
                overflow_o <= 1'b1;                // Word dropped, sticky until reset
            end

            word_o.valid <= pop;
            if (pop) begin
                rd_ptr_q           <= rd_ptr_q + 1'b1;
                word_o.is_metering <= read_entry[`PIXEL_WIDTH];
                word_o.data        <= read_entry[`PIXEL_WIDTH-1:0];
            end

            credits_q <= credits_q - CREDIT_WIDTH'(pop) + CREDIT_WIDTH'(credit_return_i);
        end
    end

    // Metering result must line up with the crop frame end and never hit a pixel
    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        pixel_i.frame_end == metering_valid_i && !(metering_valid_i && pixel_i.valid))
        else $error("Metering byte not aligned with cropped frame end");

    // Consumer returns no more credits than words it received
    assert property (@(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
        credits_q <= CREDIT_WIDTH'(`OUTPUT_CREDITS))
        else $error("Credit count above OUTPUT_CREDITS");

endmodule

`default_nettype wire

// ==== source/pan_crop.sv ====
/*
 * Pan crop window
 * Keeps only pixels inside a per-frame window and re-bases their
 * coordinates to the window origin
 */

`timescale 1ns/1ps
`default_nettype none

`include "camera_defines.svh"

module pan_crop (
    input  wire logic                     mipi_byte_clock,
    input  wire logic                     mipi_byte_reset_n,
    input  wire camera_pkg::crop_window_t window_i,
    input  wire camera_pkg::pixel_t       pixel_i,
    output camera_pkg::pixel_t            pixel_o
);

    camera_pkg::crop_window_t window_q;    // Held for the whole frame
    camera_pkg::crop_window_t window;
    logic                     x_inside;
    logic                     y_inside;

    // New bounds apply from the frame start marker onwards
    assign window = pixel_i.frame_start ? window_i : window_q;

    assign x_inside = (pixel_i.x >= window.x_start) && (pixel_i.x < window.x_end);
    assign y_inside = (pixel_i.y >= window.y_start) && (pixel_i.y < window.y_end);

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            window_q <= '0;
        end else if (pixel_i.frame_start) begin
            window_q <= window_i;
        end
    end

    always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            pixel_o <= '0;
        end else begin
            pixel_o.valid       <= pixel_i.valid && x_inside && y_inside;
            pixel_o.frame_start <= pixel_i.frame_start;    // Markers pass unchanged
            pixel_o.frame_end   <= pixel_i.frame_end;
            pixel_o.x           <= pixel_i.x - window.x_start;
            pixel_o.y           <= pixel_i.y - window.y_start;
            pixel_o.data        <= pixel_i.data;
        end
    end

endmodule

`default_nettype wire

// ==== tb/camera_tb_model.svh ====
/*
 * Camera front end testbench model
 * Random source, CSI-2 packet byte builder and expected output words
 */

`ifndef CAMERA_TB_MODEL_SVH
`define CAMERA_TB_MODEL_SVH

logic [31:0] lfsr_state = 32'h94c9ed77;
logic [8:0]  packet_bytes [$];     // Packet start flag above the byte
logic [7:0]  payload [$];
logic [7:0]  frame_pixels [$];     // Raster order, y * width + x
logic [8:0]  expected_words [$];   // Metering tag above the data

// Galois LFSR, one step per bit taken
function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value      = {value[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return value;
endfunction

function automatic int random_range(input int low, input int high);
    logic [31:0] span;
    span = 32'(high - low + 1);
    return low + int'(random_bits(8) % span);
endfunction

// Data identifier with random virtual channel, word count, filler ECC
function automatic void add_header(input logic [5:0] data_type, input logic [15:0] word_count);
    logic [1:0] channel;
    logic [7:0] ecc;
    channel = 2'(random_bits(2));
    ecc     = 8'(random_bits(8));
    packet_bytes.push_back({1'b1, channel, data_type});
    packet_bytes.push_back({1'b0, word_count[7:0]});
    packet_bytes.push_back({1'b0, word_count[15:8]});
    packet_bytes.push_back({1'b0, ecc});
endfunction

function automatic void add_long_packet(input logic [5:0] data_type);
    add_header(data_type, 16'(payload.size()));
    foreach (payload[i]) packet_bytes.push_back({1'b0, payload[i]});
    packet_bytes.push_back({1'b0, 8'(random_bits(8))});   // CRC filler
    packet_bytes.push_back({1'b0, 8'(random_bits(8))});
endfunction

// Cropped pixels in raster order, then the saturated metering byte
function automatic void model_frame(input int width, input int height,
                                    input int x_start, input int x_end,
                                    input int y_start, input int y_end);
    logic [31:0] sum;
    logic [31:0] scaled;
    sum = '0;
    for (int y = 0; y < height; y++) begin
        for (int x = 0; x < width; x++) begin
            sum = sum + 32'(frame_pixels[y * width + x]);
            if (x >= x_start && x < x_end && y >= y_start && y < y_end)
                expected_words.push_back({1'b0, frame_pixels[y * width + x]});
        end
    end
    scaled = sum >> `METERING_SHIFT;
    expected_words.push_back({1'b1, (scaled > 32'd255) ? 8'hff : scaled[7:0]});
endfunction

`endif

// ==== tb/camera_front_end_tb.sv ====
/*
 * Camera front end testbench
 * Random CSI-2 frames in, cropped pixels and metering bytes checked
 * at the credit-controlled output
 */

`timescale 1ns/1ps
`default_nettype none

`include "camera_defines.svh"

module camera_front_end_tb;

    localparam int     NUM_FRAMES      = 12;
    localparam int     MAX_GAP         = 3;
    localparam int     MAX_FRAME_BYTES = 800;   // 40 x 12 bright frame with extra packets
    localparam longint TIMEOUT_NS      = longint'(NUM_FRAMES * MAX_FRAME_BYTES * (MAX_GAP + 2) * 10)
                                         + 64'd2000;

    logic                     mipi_byte_clock;
    logic                     mipi_byte_reset_n;
    camera_pkg::mipi_byte_t   byte_stim;
    camera_pkg::crop_window_t crop_window;
    logic                     credit_return;
    camera_pkg::output_word_t word_out;
    logic                     overflow;
    int                       cycle = 0;
    int                       last_due = 0;
    int                       outstanding = 0;
    int                       due_cycles [$];   // Cycles at which a credit goes back

    `include "camera_tb_model.svh"

    camera_front_end camera_front_end_i (
        .mipi_byte_clock   (mipi_byte_clock),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .byte_i            (byte_stim),
        .crop_window_i     (crop_window),
        .credit_return_i   (credit_return),
        .word_o            (word_out),
        .overflow_o        (overflow)
    );

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    initial begin
        mipi_byte_clock = 1'b0;
        forever #5 mipi_byte_clock = ~mipi_byte_clock;
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run("Timeout: the expected output words did not all arrive");
    end

    // Sends the built packet with random idle gaps between bytes
    task automatic send_packet();
        int gap;
        while (packet_bytes.size() != 0) begin
            @(negedge mipi_byte_clock);
            byte_stim.valid        = 1'b1;
            byte_stim.packet_start = packet_bytes[0][8];
            byte_stim.data         = packet_bytes[0][7:0];
            void'(packet_bytes.pop_front());
            gap = random_range(0, MAX_GAP);
            repeat (gap) begin
                @(negedge mipi_byte_clock);
                byte_stim.valid = 1'b0;
            end
        end
        @(negedge mipi_byte_clock);
        byte_stim.valid = 1'b0;
    endtask

    task automatic run_frame(input int frame_number, input bit bright);
        int width;
        int height;
        int x_start;
        int x_end;
        int y_start;
        int y_end;
        width   = bright ? 40 : random_range(4, 20);   // 40 x 12 so the sum saturates
        height  = bright ? 12 : random_range(2, 12);
        x_start = random_range(0, width - 1);
        x_end   = x_start + random_range(1, width + 1 - x_start);
        y_start = random_range(0, height - 1);
        y_end   = y_start + random_range(1, height + 1 - y_start);
        frame_pixels.delete();
        for (int i = 0; i < width * height; i++) begin
            frame_pixels.push_back(bright ? (8'hf0 | 8'(random_bits(4))) : 8'(random_bits(8)));
        end
        model_frame(width, height, x_start, x_end, y_start, y_end);

        crop_window.x_start = `COORD_WIDTH'(x_start);
        crop_window.x_end   = `COORD_WIDTH'(x_end);
        crop_window.y_start = `COORD_WIDTH'(y_start);
        crop_window.y_end   = `COORD_WIDTH'(y_end);
        add_header(camera_pkg::DT_FRAME_START, 16'(frame_number));
        send_packet();

        for (int y = 0; y < height; y++) begin
            payload.delete();
            for (int x = 0; x < width; x++) payload.push_back(frame_pixels[y * width + x]);
            add_long_packet(camera_pkg::DT_RAW8);
            send_packet();
            if (y == 0) begin
                // Mid-frame window change that must wait for the next frame
                crop_window.x_start = `COORD_WIDTH'(random_bits(11));
                crop_window.x_end   = `COORD_WIDTH'(random_bits(11));
                crop_window.y_start = `COORD_WIDTH'(random_bits(11));
                crop_window.y_end   = `COORD_WIDTH'(random_bits(11));
            end
            if (random_bits(2) == 32'd0) begin
                if (random_bits(1) == 32'd1) begin
                    payload.delete();
                    repeat (random_range(1, 8)) payload.push_back(8'(random_bits(8)));
                    add_long_packet(6'h2B);      // RAW10 line that the parser skips
                end else begin
                    add_header(6'h08, 16'(random_bits(16)));   // Generic short packet
                end
                send_packet();
            end
        end

        add_header(camera_pkg::DT_FRAME_END, 16'(frame_number));
        send_packet();
    endtask

    // Checks each word and returns its credit after a random delay
    always @(negedge mipi_byte_clock) begin : consumer
        logic [8:0] expected;
        int         due;
        cycle = cycle + 1;
        assert (overflow === 1'b0)
            else fail_run($sformatf("** Error: overflow_o expected 0 got %h", overflow));
        assert (word_out.valid === 1'b0 || word_out.valid === 1'b1)
            else fail_run("The output valid flag is unknown");
        if (word_out.valid === 1'b1) begin
            assert (expected_words.size() != 0)
                else fail_run("An output word arrived when none was expected");
            expected = expected_words.pop_front();
            assert (word_out.is_metering === expected[8])
                else fail_run($sformatf("** Error: word_o.is_metering expected %h got %h",
                                        expected[8], word_out.is_metering));
            assert (word_out.data === expected[7:0])
                else fail_run($sformatf("** Error: word_o.data expected %h got %h",
                                        expected[7:0], word_out.data));
            outstanding = outstanding + 1;
            assert (outstanding <= `OUTPUT_CREDITS)
                else fail_run($sformatf("** Error: outstanding words expected <= %h got %h",
                                        `OUTPUT_CREDITS, outstanding));
            due = cycle + random_range(0, MAX_GAP);
            if (due <= last_due) due = last_due + 1;  // One credit per cycle
            last_due = due;
            due_cycles.push_back(due);
        end
        if (due_cycles.size() != 0 && due_cycles[0] <= cycle) begin
            void'(due_cycles.pop_front());
            credit_return = 1'b1;
            outstanding   = outstanding - 1;
        end else begin
            credit_return = 1'b0;
        end
    end

    initial begin
        mipi_byte_reset_n = 1'b0;
        byte_stim         = '0;
        crop_window       = '0;
        credit_return     = 1'b0;
        repeat (10) @(posedge mipi_byte_clock);
        @(negedge mipi_byte_clock);
        mipi_byte_reset_n = 1'b1;
        repeat (20) @(negedge mipi_byte_clock);   // Quiet period with no output words

        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f, (f % 4) == 3);
        end

        while (expected_words.size() != 0) @(negedge mipi_byte_clock);
        repeat (20) @(negedge mipi_byte_clock);

        if (expected_words.size() == 0 && outstanding == 0 && overflow === 1'b0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            fail_run("Output stream did not end cleanly with all credits returned");
        end
    end

endmodule

`default_nettype wire
